// ==== flist.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/mem_access_if.sv
verilog/access_decode.sv
verilog/data_mem_array.sv
verilog/load_result.sv
verilog/data_mem_top.sv
sim/tb_data_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_data_mem -f flist.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_data_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi
echo "Simulation finished without errors"
exit 0

// ==== sim/tb_data_mem.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_data_mem;
    import lsu_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_EMPTY = 20;
    localparam int N_PAIRS = 30;
    localparam int N_FAULT = 10;
    localparam int N_SAME = 10;
    localparam int N_BURST = 16;
    localparam int N_CHECK = 20;
    localparam int N_MIXED = 400;
    localparam int TEST_CYCLES = 2 + 2 * N_EMPTY + 6 * N_PAIRS + 10 * N_FAULT + 2 * N_SAME
                                 + N_BURST + 4 * N_CHECK + N_MIXED + 3;

    logic        clk = 1'b0;
    logic        reset;
    logic        commit_write;
    logic        commit_read;
    logic [2:0]  commit_funct3;
    logic [31:0] commit_addr;
    logic [31:0] commit_value;
    logic        ls_read;
    logic [2:0]  ls_funct3;
    logic [31:0] ls_addr;
    logic [31:0] ls_data;
    logic        ls_valid;
    logic        ls_fault;
    logic        commit_exception;

    logic [7:0]  model_mem [`MEM_BYTES];
    logic [31:0] lfsr = 32'hc04e;
    logic        exp_ls_valid = 1'b0;   // Expectations for the cycle being driven
    logic [31:0] exp_ls_data = 32'd0;
    logic        exp_ls_fault = 1'b0;
    logic        exp_exc = 1'b0;
    int          error_count = 0;
    int          check_count = 0;

    data_mem_top dut_i (
        .clk(clk), .reset(reset),
        .commit_write(commit_write), .commit_read(commit_read),
        .commit_funct3(commit_funct3), .commit_addr(commit_addr),
        .commit_value(commit_value), .ls_read(ls_read),
        .ls_funct3(ls_funct3), .ls_addr(ls_addr),
        .ls_data(ls_data), .ls_valid(ls_valid),
        .ls_fault(ls_fault), .commit_exception(commit_exception)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [2:0] pick_load_f3();
        case (rand_bits(3))
            0: return F3_LB;
            1: return F3_LH;
            2, 5: return F3_LW;
            3, 7: return F3_LBU;
            4: return F3_LHU;
            default: return 3'b110;              // Unused code
        endcase
    endfunction

    function automatic logic [2:0] pick_store_f3();
        case (rand_bits(3))
            0, 1: return F3_LB;
            2, 3: return F3_LH;
            4, 5: return F3_LW;
            6: return 3'b011;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] align_addr(input logic [2:0] f3, input logic [31:0] addr);
        case (f3)
            F3_LH, F3_LHU: return {addr[31:1], 1'b0};
            F3_LW: return {addr[31:2], 2'b00};
            default: return addr;
        endcase
    endfunction

    // Expected {fault, value} of a load read straight from the byte model
    function automatic logic [32:0] expected_load(input logic [2:0] f3, input logic [31:0] addr);
        mem_addr_u   a;
        logic [11:0] idx;
        logic [7:0]  b0, b1, b2, b3;
        a.flat = addr;
        idx = a.flat[11:0];                      // Wraps on the 4 KB window
        b0 = model_mem[idx];
        b1 = model_mem[idx + 12'd1];
        b2 = model_mem[idx + 12'd2];
        b3 = model_mem[idx + 12'd3];
        case (f3)
            F3_LB: return {1'b0, {24{b0[7]}}, b0};
            F3_LBU: return {1'b0, 24'd0, b0};
            F3_LH: return idx[0] ? 33'h1_0000_0000 : {1'b0, {16{b1[7]}}, b1, b0};
            F3_LHU: return idx[0] ? 33'h1_0000_0000 : {1'b0, 16'd0, b1, b0};
            F3_LW: return (idx[1:0] != 2'b00) ? 33'h1_0000_0000 : {1'b0, b3, b2, b1, b0};
            default: return 33'h1_0000_0000;
        endcase
    endfunction

    task automatic apply_store(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] val);
        logic [11:0] idx;
        idx = addr[11:0];
        if (f3 == F3_LB) begin
            model_mem[idx] = val[7:0];
        end else if (f3 == F3_LH && !idx[0]) begin
            model_mem[idx] = val[7:0];
            model_mem[idx + 12'd1] = val[15:8];
        end else if (f3 == F3_LW && idx[1:0] == 2'b00) begin
            for (int i = 0; i < 4; i++) begin
                model_mem[idx + 12'(i)] = val[i*8 +: 8];
            end
        end
    endtask

    task automatic drive_cycle(input logic cw, input logic cr, input logic [2:0] cf3,
                               input logic [31:0] caddr, input logic [31:0] cval,
                               input logic lr, input logic [2:0] lf3, input logic [31:0] laddr);
        logic [32:0] r;
        @(negedge clk);
        commit_write = cw;
        commit_read = cr;
        commit_funct3 = cf3;
        commit_addr = caddr;
        commit_value = cval;
        ls_read = lr;
        ls_funct3 = lf3;
        ls_addr = laddr;
        r = expected_load(lf3, laddr);           // Before this edge's store
        exp_ls_valid = lr;
        exp_ls_fault = lr & r[32];
        exp_ls_data = r[31:0];
        r = expected_load(cf3, caddr);
        exp_exc = cr & (r[32] | (r[31:0] != cval));
        if (cw) begin
            apply_store(cf3, caddr, cval);
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(0, 0, 3'd0, 32'd0, 32'd0, 0, 3'd0, 32'd0);
    endtask

    task automatic issue_load(input logic [2:0] f3, input logic [31:0] addr);
        drive_cycle(0, 0, 3'd0, 32'd0, 32'd0, 1, f3, addr);
    endtask

    task automatic retire_store(input logic [2:0] f3, input logic [31:0] addr,
                                input logic [31:0] val);
        drive_cycle(1, 0, f3, addr, val, 0, 3'd0, 32'd0);
    endtask

    task automatic check_commit(input logic [2:0] f3, input logic [31:0] addr,
                                input logic [31:0] val);
        drive_cycle(0, 1, f3, addr, val, 0, 3'd0, 32'd0);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] got);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expv, got);
        error_count++;
    endtask

    // Outputs settle well before the sample 1 ns after the rising edge
    initial begin : compare
        logic        q_valid;
        logic [31:0] q_data;
        logic        q_fault;
        logic        q_exc;
        forever begin
            @(posedge clk);
            q_valid = exp_ls_valid;               // Load issued at this edge
            q_data = exp_ls_data;
            q_fault = exp_ls_fault;
            q_exc = exp_exc;
            #1;
            check_count++;
            assert (ls_valid === q_valid)
                else report_mismatch("ls_valid", 32'(q_valid), 32'(ls_valid));
            assert (ls_fault === q_fault)
                else report_mismatch("ls_fault", 32'(q_fault), 32'(ls_fault));
            assert (!q_valid || ls_data === q_data)
                else report_mismatch("ls_data", q_data, ls_data);
            assert (commit_exception === q_exc)
                else report_mismatch("commit_exception", 32'(q_exc), 32'(commit_exception));
        end
    end

    initial begin : watchdog
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout: simulation did not finish within %0d cycles", TEST_CYCLES + 100);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] op;
        logic [2:0]  f3;
        logic [2:0]  cf3;
        logic [31:0] caddr;
        logic [31:0] cval;
        logic [32:0] r;
        reset = 1'b1;
        commit_write = 1'b0;
        commit_read = 1'b0;
        commit_funct3 = 3'd0;
        commit_addr = 32'd0;
        commit_value = 32'd0;
        ls_read = 1'b0;
        ls_funct3 = 3'd0;
        ls_addr = 32'd0;
        for (int i = 0; i < `MEM_BYTES; i++) begin
            model_mem[i] = 8'd0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < N_EMPTY; i++) begin   // Loads with idle gaps on cleared memory
            f3 = pick_load_f3();
            issue_load(f3, align_addr(f3, rand_bits(32)));
            idle_cycle();
        end

        for (int i = 0; i < N_PAIRS; i++) begin   // Small window gives many partial overwrites
            f3 = pick_store_f3();
            retire_store(f3, align_addr(f3, rand_bits(6)), rand_bits(32));
            addr = rand_bits(6);
            issue_load(F3_LB, addr);
            issue_load(F3_LBU, addr);
            issue_load(F3_LH, align_addr(F3_LH, addr));
            issue_load(F3_LHU, align_addr(F3_LHU, addr));
            issue_load(F3_LW, align_addr(F3_LW, addr));
        end

        for (int i = 0; i < N_FAULT; i++) begin
            addr = rand_bits(6) | 32'd1;
            data = rand_bits(32);
            issue_load(F3_LH, addr);
            issue_load(F3_LHU, addr);
            issue_load(F3_LW, addr);
            issue_load(F3_LW, {addr[31:2], 2'b10});
            issue_load(3'b011, addr);
            issue_load(3'b110, align_addr(F3_LW, addr));
            retire_store(F3_LH, addr, data);
            retire_store(F3_LW, {addr[31:2], 2'b10}, data);
            retire_store(3'b111, align_addr(F3_LW, addr), data);
            issue_load(F3_LW, align_addr(F3_LW, addr));
        end

        for (int i = 0; i < N_SAME; i++) begin    // Store and load at one edge
            addr = align_addr(F3_LW, rand_bits(6));
            drive_cycle(1, 0, F3_LW, addr, rand_bits(32), 1, F3_LW, addr);
            issue_load(F3_LW, addr);
        end
        for (int i = 0; i < N_BURST; i++) begin
            f3 = pick_load_f3();
            issue_load(f3, align_addr(f3, rand_bits(6)));
        end

        for (int i = 0; i < N_CHECK; i++) begin
            f3 = pick_load_f3();
            addr = align_addr(f3, rand_bits(6));
            r = expected_load(f3, addr);
            check_commit(f3, addr, r[31:0]);
        end
        for (int i = 0; i < N_CHECK; i++) begin
            f3 = pick_load_f3();
            addr = align_addr(f3, rand_bits(6));
            r = expected_load(f3, addr);
            check_commit(f3, addr, r[31:0] ^ (32'd1 << rand_bits(5)));
            check_commit(F3_LW, addr | 32'd2, r[31:0]);
            check_commit(3'b111, addr, r[31:0]);
        end

        for (int i = 0; i < N_MIXED; i++) begin   // Random upper bits make the address wrap
            op = rand_bits(2);
            cf3 = (op == 32'd1) ? pick_store_f3() : pick_load_f3();
            caddr = rand_bits(32) & 32'hffff_f03f;
            if (rand_bits(2) != 32'd0) begin
                caddr = align_addr(cf3, caddr);
            end
            r = expected_load(cf3, caddr);
            cval = rand_bits(32);
            if (op == 32'd2 && rand_bits(1) == 32'd1) begin
                cval = r[31:0];
            end
            f3 = pick_load_f3();
            addr = align_addr(f3, rand_bits(32) & 32'hffff_f03f);
            drive_cycle(op == 32'd1, op == 32'd2, cf3, caddr, cval,
                        rand_bits(2) != 32'd0, f3, addr);
        end

        repeat (3) idle_cycle();
        $display("Checked cycles: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog/data_mem_top.sv ====
`timescale 1ns/1ps

module data_mem_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        commit_write,
    input  logic        commit_read,
    input  logic [2:0]  commit_funct3,
    input  logic [31:0] commit_addr,
    input  logic [31:0] commit_value,
    input  logic        ls_read,
    input  logic [2:0]  ls_funct3,
    input  logic [31:0] ls_addr,
    output logic [31:0] ls_data,
    output logic        ls_valid,
    output logic        ls_fault,
    output logic        commit_exception
);

    mem_access_if commit_acc ();    // Shared by retiring stores and load checks
    mem_access_if ls_acc ();

    logic [31:0] ls_word;
    logic        ls_word_valid;
    logic [31:0] commit_word;

    access_decode u_commit_dec (
        .funct3 (commit_funct3),
        .addr   (commit_addr),
        .strobe (commit_write | commit_read),
        .acc    (commit_acc)
    );

    access_decode u_ls_dec (
        .funct3 (ls_funct3),
        .addr   (ls_addr),
        .strobe (ls_read),
        .acc    (ls_acc)
    );

    data_mem_array u_array (
        .clk           (clk),
        .reset         (reset),
        .write         (commit_write),
        .wdata         (commit_value),
        .commit_acc    (commit_acc),
        .ls_acc        (ls_acc),
        .ls_word       (ls_word),
        .ls_word_valid (ls_word_valid),
        .commit_word   (commit_word)
    );

    load_result u_result (
        .clk              (clk),
        .reset            (reset),
        .ls_acc           (ls_acc),
        .ls_word          (ls_word),
        .ls_word_valid    (ls_word_valid),
        .commit_acc       (commit_acc),
        .commit_read      (commit_read),
        .commit_word      (commit_word),
        .commit_value     (commit_value),
        .ls_data          (ls_data),
        .ls_valid         (ls_valid),
        .ls_fault         (ls_fault),
        .commit_exception (commit_exception)
    );

endmodule

// ==== verilog/load_result.sv ====
`timescale 1ns/1ps

module load_result (
    input  logic        clk,
    input  logic        reset,
    mem_access_if.res   ls_acc,
    input  logic [31:0] ls_word,
    input  logic        ls_word_valid,
    mem_access_if.res   commit_acc,
    input  logic        commit_read,
    input  logic [31:0] commit_word,
    input  logic [31:0] commit_value,
    output logic [31:0] ls_data,
    output logic        ls_valid,
    output logic        ls_fault,
    output logic        commit_exception
);
    import lsu_pkg::*;

    logic [1:0]  ls_offset_q;
    mem_width_e  ls_width_q;
    logic        ls_signed_q;
    logic        ls_fault_q;
    logic [31:0] commit_load;
    logic        commit_check;

    // Byte/half select and extension of a raw word
    function automatic logic [31:0] format_load(
        input logic [31:0] word,
        input logic [1:0]  offset,
        input mem_width_e  width,
        input logic        is_signed,
        input logic        fault
    );
        logic [31:0] shifted;
        logic [31:0] result;
        shifted = word >> {offset, 3'b000};
        case (width)
            WIDTH_BYTE: result = {{24{is_signed & shifted[7]}}, shifted[7:0]};
            WIDTH_HALF: result = {{16{is_signed & shifted[15]}}, shifted[15:0]};
            default:    result = word;
        endcase
        if (fault) begin
            result = 32'd0;
        end
        return result;
    endfunction

    // Same edge as the array's word register
    always_ff @(posedge clk) begin
        if (reset) begin
            ls_fault_q <= 1'b0;
        end else begin
            ls_fault_q <= ls_acc.valid & ls_acc.fault;
        end
    end

    always_ff @(posedge clk) begin
        if (ls_acc.valid) begin
            ls_offset_q <= ls_acc.offset;
            ls_width_q  <= ls_acc.width;
            ls_signed_q <= ls_acc.is_signed;
        end
    end

    assign ls_valid = ls_word_valid;
    assign ls_fault = ls_fault_q;
    assign ls_data  = format_load(ls_word, ls_offset_q, ls_width_q, ls_signed_q, ls_fault_q);

    // Retired load must still match memory
    assign commit_check = commit_read & commit_acc.valid;
    assign commit_load  = format_load(commit_word, commit_acc.offset, commit_acc.width,
                                      commit_acc.is_signed, commit_acc.fault);
    assign commit_exception = commit_check &
                              (commit_acc.fault | (commit_load != commit_value));

    a_fault_needs_valid: assert property (
        @(posedge clk) disable iff (reset) ls_fault |-> ls_valid
    );

endmodule

// ==== verilog/data_mem_array.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module data_mem_array (
    input  logic        clk,
    input  logic        reset,
    input  logic        write,
    input  logic [31:0] wdata,
    mem_access_if.mem   commit_acc,
    mem_access_if.mem   ls_acc,
    output logic [31:0] ls_word,
    output logic        ls_word_valid,
    output logic [31:0] commit_word
);

    logic [3:0][7:0] mem [`MEM_WORDS];

    logic [1:0]  lane_shift;
    logic [31:0] wdata_sh;

    // Lowest enabled lane gives the store offset
    always_comb begin
        casez (commit_acc.byte_en)
            4'b???1: lane_shift = 2'd0;
            4'b??10: lane_shift = 2'd1;
            4'b?100: lane_shift = 2'd2;
            4'b1000: lane_shift = 2'd3;
            default: lane_shift = 2'd0;
        endcase
    end

    assign wdata_sh = wdata << {lane_shift, 3'b000};

    // Commit store port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write && !commit_acc.fault) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (commit_acc.byte_en[lane]) begin
                    mem[commit_acc.word_idx][lane] <= wdata_sh[lane*8 +: 8];
                end
            end
        end
    end

    // Speculative read sees memory before this edge's store
    always_ff @(posedge clk) begin
        if (reset) begin
            ls_word_valid <= 1'b0;
        end else begin
            ls_word_valid <= ls_acc.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ls_acc.valid) begin
            ls_word <= ls_acc.fault ? 32'd0 : mem[ls_acc.word_idx];
        end
    end

    // Combinational commit check read
    assign commit_word = mem[commit_acc.word_idx];

    a_ls_valid_after_reset: assert property (
        @(posedge clk) reset |=> !ls_word_valid
    );

endmodule

// ==== verilog/access_decode.sv ====
`timescale 1ns/1ps

module access_decode (
    input  logic [2:0]        funct3,
    input  lsu_pkg::mem_addr_u addr,
    input  logic              strobe,
    mem_access_if.dec         acc
);
    import lsu_pkg::*;

    mem_width_e width;
    logic       is_signed;
    logic       bad_code;
    logic       misaligned;
    logic       fault;
    logic [1:0] offset;

    assign offset = addr.fields.offset;

    // Size and sign from funct3 with store codes matching LB/LH/LW
    always_comb begin
        width     = WIDTH_WORD;
        is_signed = 1'b0;
        bad_code  = 1'b0;
        case (funct3)
            F3_LB: begin
                width     = WIDTH_BYTE;
                is_signed = 1'b1;
            end
            F3_LH: begin
                width     = WIDTH_HALF;
                is_signed = 1'b1;
            end
            F3_LW: begin
                width     = WIDTH_WORD;
                is_signed = 1'b1;
            end
            F3_LBU: width = WIDTH_BYTE;
            F3_LHU: width = WIDTH_HALF;
            default: bad_code = 1'b1;               // 011, 110, 111
        endcase
    end

    // No access may span two words
    assign misaligned = (width == WIDTH_HALF && offset[0]) ||
                        (width == WIDTH_WORD && offset != 2'b00);
    assign fault = bad_code | misaligned;

    always_comb begin
        case (width)
            WIDTH_BYTE: acc.byte_en = 4'b0001 << offset;
            WIDTH_HALF: acc.byte_en = 4'b0011 << offset;
            default:    acc.byte_en = 4'b1111;
        endcase
        if (fault) begin
            acc.byte_en = 4'b0000;                  // Faulted access touches no lane
        end
    end

    assign acc.valid     = strobe;
    assign acc.word_idx  = addr.fields.word_idx;  // Upper bits dropped so the address wraps
    assign acc.offset    = offset;
    assign acc.width     = width;
    assign acc.is_signed = is_signed;
    assign acc.fault     = fault;

endmodule

// ==== verilog/mem_access_if.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

interface mem_access_if;
    import lsu_pkg::*;

    logic                   valid;      // Access strobe for this cycle
    logic [`WORD_IDX_W-1:0] word_idx;
    logic [3:0]             byte_en;    // All zero when faulted
    logic [1:0]             offset;
    mem_width_e             width;
    logic                   is_signed;
    logic                   fault;      // Misaligned or unused funct3

    modport dec (
        output valid, word_idx, byte_en, offset, width, is_signed, fault
    );

    modport mem (
        input valid, word_idx, byte_en, fault
    );

    modport res (
        input offset, width, is_signed, valid, fault
    );

endinterface

// ==== verilog/lsu_pkg.sv ====
`include "lsu_consts.svh"

package lsu_pkg;

    // Access size of a load or store
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'd0,
        WIDTH_HALF = 2'd1,
        WIDTH_WORD = 2'd2
    } mem_width_e;

    // Address split for the word-organized array
    typedef struct packed {
        logic [31-`WORD_IDX_W-2:0] upper;      // Ignored above the 4 KB window
        logic [`WORD_IDX_W-1:0]    word_idx;
        logic [1:0]                offset;     // Byte lane within the word
    } mem_addr_s;

    typedef union packed {
        logic [31:0] flat;                     // Plain byte address
        mem_addr_s   fields;
    } mem_addr_u;

    // RISC-V load funct3 codes whose first three also encode stores
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

endpackage

// ==== verilog/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Geometry of the byte-addressed data memory
`define MEM_BYTES   4096
`define MEM_WORDS   1024     // Four byte lanes per word
`define WORD_IDX_W  10       // log2 of MEM_WORDS

`endif
